// File: Makefile
# Verilator build and run for the multiply/divide unit

VERILATOR ?= verilator
TOP       ?= mult_div_tb
FILELIST  ?= mult_div.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "NO ERRORS" $(LOG) || { echo "run ended without a result, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/mdu_config.svh
// multiply/divide unit configuration
`ifndef MDU_CONFIG_SVH
`define MDU_CONFIG_SVH

// data word width
`define MDU_XLEN 32

// shift-subtract steps of the divider, one per quotient bit
`define MDU_DIV_CYCLES 32

// cycles from mult start to product valid
`define MDU_MULT_LAT 2

`endif

// File: design/mdu_data_pkg.sv
// mdu data types
`include "mdu_config.svh"

package mdu_data_pkg;

    // single data word
    typedef logic [`MDU_XLEN-1:0] word_t;

    // hi in the upper half, lo in the lower half
    typedef logic [2*`MDU_XLEN-1:0] dword_t;

    // bit 1 writes hi, bit 0 writes lo
    typedef logic [1:0] hilo_wen_t;

    localparam hilo_wen_t HILO_WEN_NONE = 2'b00;
    localparam hilo_wen_t HILO_WEN_LO   = 2'b01;
    localparam hilo_wen_t HILO_WEN_HI   = 2'b10;
    localparam hilo_wen_t HILO_WEN_BOTH = 2'b11;

endpackage

// File: design/mdu_div.sv
// iterative restoring divider
`timescale 1ns/1ps
`include "mdu_config.svh"

module mdu_div (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                is_signed,
    input  mdu_data_pkg::word_t dividend,
    input  mdu_data_pkg::word_t divisor,
    output mdu_data_pkg::word_t quotient,
    output mdu_data_pkg::word_t remainder,
    output logic                busy,
    output logic                done
);

    localparam int CNT_W = $clog2(`MDU_DIV_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MDU_DIV_CYCLES - 1);

    logic                running;
    logic                done_q;
    logic [CNT_W-1:0]    cnt;

    logic                neg_dvd;
    logic                neg_dvs;
    mdu_data_pkg::word_t abs_dvd;
    mdu_data_pkg::word_t abs_dvs;

    mdu_data_pkg::word_t rem_q;    // partial remainder
    mdu_data_pkg::word_t quo_q;    // dividend bits shift out, quotient bits shift in
    mdu_data_pkg::word_t dvs_q;
    logic                neg_quo_q;
    logic                neg_rem_q;

    logic [`MDU_XLEN:0]  shifted;
    logic [`MDU_XLEN:0]  diff;

    // magnitudes of the operands
    assign neg_dvd = is_signed & dividend[`MDU_XLEN-1];
    assign neg_dvs = is_signed & divisor[`MDU_XLEN-1];
    assign abs_dvd = neg_dvd ? -dividend : dividend;  // 0x8000_0000 stays as unsigned
    assign abs_dvs = neg_dvs ? -divisor : divisor;

    // one restoring step
    assign shifted = {rem_q, quo_q[`MDU_XLEN-1]};
    assign diff    = shifted - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            done_q  <= 1'b0;
            cnt     <= '0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_LAST) begin
                    running <= 1'b0;
                    done_q  <= 1'b1;  // last step lands here
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q     <= '0;
            quo_q     <= abs_dvd;
            dvs_q     <= abs_dvs;
            neg_quo_q <= neg_dvd ^ neg_dvs;
            neg_rem_q <= neg_dvd;  // remainder follows the dividend
        end else if (running) begin
            if (diff[`MDU_XLEN]) begin
                // borrow, restore
                rem_q <= shifted[`MDU_XLEN-1:0];
                quo_q <= {quo_q[`MDU_XLEN-2:0], 1'b0};
            end else begin
                rem_q <= diff[`MDU_XLEN-1:0];
                quo_q <= {quo_q[`MDU_XLEN-2:0], 1'b1};
            end
        end
    end

    // sign fix-up during the done cycle
    // a zero divisor never borrows, giving all-ones and the dividend back
    assign quotient  = neg_quo_q ? -quo_q : quo_q;
    assign remainder = neg_rem_q ? -rem_q : rem_q;

    assign busy = running | done_q;
    assign done = done_q;

endmodule

// File: design/mdu_hilo.sv
// hi/lo register pair
`timescale 1ns/1ps
`include "mdu_config.svh"

module mdu_hilo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mdu_data_pkg::hilo_wen_t  wen,
    input  mdu_data_pkg::dword_t     wdata,
    output mdu_data_pkg::word_t      hi,
    output mdu_data_pkg::word_t      lo
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi <= '0;
        end else if (wen[1]) begin
            hi <= wdata[2*`MDU_XLEN-1:`MDU_XLEN];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lo <= '0;
        end else if (wen[0]) begin
            lo <= wdata[`MDU_XLEN-1:0];
        end
    end

endmodule

// File: design/mdu_mult.sv
// pipelined 32x32 multiplier
`timescale 1ns/1ps
`include "mdu_config.svh"

module mdu_mult (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 is_signed,
    input  mdu_data_pkg::word_t  a,
    input  mdu_data_pkg::word_t  b,
    output mdu_data_pkg::dword_t product,
    output logic                 done
);

    // operands widened by one bit so one signed multiply covers both modes
    logic signed [`MDU_XLEN:0]     a_q;
    logic signed [`MDU_XLEN:0]     b_q;
    logic signed [2*`MDU_XLEN+1:0] full_prod;
    logic [`MDU_MULT_LAT-1:0]      vld_q;  // one bit per stage

    // stage one, capture sign-extended operands
    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= {is_signed & a[`MDU_XLEN-1], a};
            b_q <= {is_signed & b[`MDU_XLEN-1], b};
        end
    end

    assign full_prod = a_q * b_q;

    // stage two, register the product
    always_ff @(posedge clk) begin
        if (vld_q[0]) begin
            product <= full_prod[2*`MDU_XLEN-1:0];  // upper two bits are sign copies
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[`MDU_MULT_LAT-2:0], start};
        end
    end

    assign done = vld_q[`MDU_MULT_LAT-1];

endmodule

// File: design/mdu_op_pkg.sv
// mdu operation encoding
package mdu_op_pkg;

    localparam int OP_NUM = 8;

    // one-hot operation strobe, at most one bit set
    typedef logic [OP_NUM-1:0] op_t;

    // bit positions inside op_t
    typedef enum int unsigned {
        OP_MULT  = 0,  // signed multiply
        OP_MULTU = 1,  // unsigned multiply
        OP_DIV   = 2,  // signed divide
        OP_DIVU  = 3,  // unsigned divide
        OP_MFHI  = 4,  // read hi
        OP_MFLO  = 5,  // read lo
        OP_MTHI  = 6,  // write hi from in0
        OP_MTLO  = 7   // write lo from in0
    } op_idx_e;

endpackage

// File: design/mult_div.sv
// multiply/divide unit top
`timescale 1ns/1ps
`include "mdu_config.svh"

module mult_div (
    input  logic                clk,
    input  logic                rst_n,
    input  mdu_op_pkg::op_t     op,
    input  mdu_data_pkg::word_t in0,
    input  mdu_data_pkg::word_t in1,
    output mdu_data_pkg::word_t result,
    output logic                ready
);

    logic                     mult_start;
    logic                     mult_signed;
    logic                     div_start;
    logic                     div_signed;
    mdu_data_pkg::hilo_wen_t  mt_wen;

    mdu_data_pkg::dword_t     mult_prod;
    logic                     mult_done;
    mdu_data_pkg::word_t      div_quo;
    mdu_data_pkg::word_t      div_rem;
    logic                     div_busy;
    logic                     div_done;

    mdu_data_pkg::hilo_wen_t  hilo_wen;
    mdu_data_pkg::dword_t     hilo_wdata;
    mdu_data_pkg::word_t      hi;
    mdu_data_pkg::word_t      lo;

    logic                     busy_q;  // a mult or div is in flight

    // op decode
    assign mult_start  = op[mdu_op_pkg::OP_MULT] | op[mdu_op_pkg::OP_MULTU];
    assign mult_signed = op[mdu_op_pkg::OP_MULT];
    assign div_signed  = op[mdu_op_pkg::OP_DIV];
    // divider ignores a restart while it is still running
    assign div_start   = (op[mdu_op_pkg::OP_DIV] | op[mdu_op_pkg::OP_DIVU]) & ~div_busy;
    assign mt_wen      = {op[mdu_op_pkg::OP_MTHI], op[mdu_op_pkg::OP_MTLO]};

    mdu_mult u_mult (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (mult_start),
        .is_signed (mult_signed),
        .a         (in0),
        .b         (in1),
        .product   (mult_prod),
        .done      (mult_done)
    );

    mdu_div u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (in0),
        .divisor   (in1),
        .quotient  (div_quo),
        .remainder (div_rem),
        .busy      (div_busy),
        .done      (div_done)
    );

    // write source priority: mult, div, then mt
    always_comb begin
        if (mult_done) begin
            hilo_wen   = mdu_data_pkg::HILO_WEN_BOTH;
            hilo_wdata = mult_prod;
        end else if (div_done) begin
            hilo_wen   = mdu_data_pkg::HILO_WEN_BOTH;
            hilo_wdata = {div_rem, div_quo};  // hi = remainder
        end else begin
            hilo_wen   = mt_wen;
            hilo_wdata = {in0, in0};          // wen picks the half
        end
    end

    mdu_hilo u_hilo (
        .clk   (clk),
        .rst_n (rst_n),
        .wen   (hilo_wen),
        .wdata (hilo_wdata),
        .hi    (hi),
        .lo    (lo)
    );

    // ready trails busy by one cycle in both directions
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            ready  <= 1'b0;
        end else begin
            if (busy_q) begin
                busy_q <= ~(mult_done | div_done);
            end else begin
                busy_q <= mult_start | div_start;
            end
            ready <= ~busy_q;
        end
    end

    assign result = op[mdu_op_pkg::OP_MFHI] ? hi : lo;

endmodule

// File: mult_div.f
+incdir+design
design/mdu_op_pkg.sv
design/mdu_data_pkg.sv
design/mdu_mult.sv
design/mdu_div.sv
design/mdu_hilo.sv
design/mult_div.sv
sim/mult_div_assert.sv
sim/mult_div_tb.sv

// File: sim/mult_div_assert.sv
// mdu control assertions
`timescale 1ns/1ps
`include "mdu_config.svh"

module mult_div_assert (
    input logic            clk,
    input logic            rst_n,
    input mdu_op_pkg::op_t op,
    input logic            ready
);

    logic       md_strobe;
    logic [7:0] low_cnt;  // cycles ready has been low

    assign md_strobe = op[mdu_op_pkg::OP_MULT] | op[mdu_op_pkg::OP_MULTU]
                     | op[mdu_op_pkg::OP_DIV] | op[mdu_op_pkg::OP_DIVU];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            low_cnt <= '0;
        end else if (ready) begin
            low_cnt <= '0;
        end else begin
            low_cnt <= low_cnt + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(op))
        else $error("more than one op bit set");

    assert property (@(posedge clk) disable iff (!rst_n) md_strobe |-> ready)
        else $error("mult or div issued while ready is low");

    // ready drops one edge after the strobe, seen low at the edge after that
    assert property (@(posedge clk) disable iff (!rst_n) md_strobe |-> ##2 !ready)
        else $error("ready did not fall after a mult or div");

    assert property (@(posedge clk) disable iff (!rst_n)
                     low_cnt <= 8'(`MDU_DIV_CYCLES + 3))
        else $error("ready stayed low too long");

endmodule

// File: sim/mult_div_tb.sv
// mdu testbench
`timescale 1ns/1ps
`include "mdu_config.svh"

module mult_div_tb;

    localparam int XLEN        = `MDU_XLEN;
    localparam int CLK_PERIOD  = 20;
    localparam int N_CORNER    = 16;
    localparam int N_RAND      = 16;
    localparam int N_ROWS      = N_CORNER + N_RAND;
    localparam int READY_LIMIT = 40;
    localparam int WATCHDOG_NS = (N_ROWS * 3 * READY_LIMIT + 10) * CLK_PERIOD;

    typedef struct packed {
        mdu_op_pkg::op_t      op;
        mdu_data_pkg::word_t  in0;
        mdu_data_pkg::word_t  in1;
        mdu_data_pkg::dword_t exp;  // expected {hi, lo} after the row
    } row_t;

    logic                 clk;
    logic                 rst_n;
    mdu_op_pkg::op_t      op;
    mdu_data_pkg::word_t  in0;
    mdu_data_pkg::word_t  in1;
    mdu_data_pkg::word_t  result;
    logic                 ready;

    row_t                 rows[$];
    mdu_data_pkg::dword_t model_hilo;  // reference hi/lo while the table is built
    integer               seed;
    int                   n_mismatch;
    int                   n_other;

    mult_div u_mult_div (
        .clk    (clk),
        .rst_n  (rst_n),
        .op     (op),
        .in0    (in0),
        .in1    (in1),
        .result (result),
        .ready  (ready)
    );

    bind mult_div mult_div_assert u_mult_div_assert (
        .clk   (clk),
        .rst_n (rst_n),
        .op    (op),
        .ready (ready)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic mdu_op_pkg::op_t make_op(input int unsigned idx);
        mdu_op_pkg::op_t o;
        o      = '0;
        o[idx] = 1'b1;
        return o;
    endfunction

    // expected {hi, lo} after one operation, from the unit's rules
    function automatic mdu_data_pkg::dword_t ref_model(input mdu_op_pkg::op_t o,
            input mdu_data_pkg::word_t a, input mdu_data_pkg::word_t b,
            input mdu_data_pkg::dword_t prev);
        mdu_data_pkg::dword_t ext_a;
        mdu_data_pkg::dword_t ext_b;
        mdu_data_pkg::word_t  mag_a;
        mdu_data_pkg::word_t  mag_b;
        mdu_data_pkg::word_t  q;
        mdu_data_pkg::word_t  r;
        logic                 neg_a;
        logic                 neg_b;
        if (o[mdu_op_pkg::OP_MULT] || o[mdu_op_pkg::OP_MULTU]) begin
            neg_a = o[mdu_op_pkg::OP_MULT] & a[XLEN-1];
            neg_b = o[mdu_op_pkg::OP_MULT] & b[XLEN-1];
            ext_a = {{XLEN{neg_a}}, a};
            ext_b = {{XLEN{neg_b}}, b};
            return ext_a * ext_b;  // low 64 bits are exact in both modes
        end
        if (o[mdu_op_pkg::OP_DIV] || o[mdu_op_pkg::OP_DIVU]) begin
            neg_a = o[mdu_op_pkg::OP_DIV] & a[XLEN-1];
            neg_b = o[mdu_op_pkg::OP_DIV] & b[XLEN-1];
            mag_a = neg_a ? -a : a;
            mag_b = neg_b ? -b : b;
            if (mag_b == '0) begin
                q = '1;     // divide by zero
                r = mag_a;
            end else begin
                q = mag_a / mag_b;
                r = mag_a % mag_b;
            end
            if (neg_a ^ neg_b) q = -q;
            if (neg_a) r = -r;
            return {r, q};
        end
        if (o[mdu_op_pkg::OP_MTHI]) return {a, prev[XLEN-1:0]};
        if (o[mdu_op_pkg::OP_MTLO]) return {prev[2*XLEN-1:XLEN], a};
        return prev;
    endfunction

    task automatic add_row(input int unsigned idx, input mdu_data_pkg::word_t a,
            input mdu_data_pkg::word_t b);
        row_t r;
        r.op       = make_op(idx);
        r.in0      = a;
        r.in1      = b;
        r.exp      = ref_model(r.op, a, b, model_hilo);
        model_hilo = r.exp;
        rows.push_back(r);
    endtask

    task automatic check_word(input mdu_data_pkg::word_t got,
            input mdu_data_pkg::word_t exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
            n_mismatch++;
        end
    endtask

    task automatic check_ready(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("mismatch at %0t: %s ready %b expected %b", $time, msg, got, exp);
            n_mismatch++;
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string msg);
        if (got != exp) begin
            $display("mismatch at %0t: %s %0d cycles expected %0d", $time, msg, got, exp);
            n_mismatch++;
        end
    endtask

    // falling edges until ready, -1 when it never comes
    task automatic wait_ready(output int waited);
        waited = 0;
        while (!ready && waited < READY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!ready) begin
            $display("error at %0t: ready did not return within %0d cycles",
                     $time, READY_LIMIT);
            n_other++;
            waited = -1;
        end
    endtask

    task automatic read_hilo(input mdu_data_pkg::dword_t exp, input string tag);
        op = make_op(mdu_op_pkg::OP_MFHI);
        @(negedge clk);
        check_word(result, exp[2*XLEN-1:XLEN], {tag, " hi"});
        op = make_op(mdu_op_pkg::OP_MFLO);
        @(negedge clk);
        check_word(result, exp[XLEN-1:0], {tag, " lo"});
        op = '0;
    endtask

    task automatic apply_row(input row_t r, input int idx);
        int   waited;
        int   exp_lat;
        logic is_mult;
        logic is_div;
        is_mult = r.op[mdu_op_pkg::OP_MULT] | r.op[mdu_op_pkg::OP_MULTU];
        is_div  = r.op[mdu_op_pkg::OP_DIV] | r.op[mdu_op_pkg::OP_DIVU];
        op  = r.op;
        in0 = r.in0;
        in1 = r.in1;
        @(negedge clk);
        op = '0;  // one-cycle strobe
        if (is_mult || is_div) begin
            exp_lat = is_mult ? `MDU_MULT_LAT + 1 : `MDU_DIV_CYCLES + 2;
            @(negedge clk);
            check_ready(ready, 1'b0, $sformatf("row %0d after strobe", idx));
            wait_ready(waited);
            if (waited >= 0) begin
                check_latency(waited + 1, exp_lat, $sformatf("row %0d ready latency", idx));
            end
        end else begin
            repeat (2) begin
                @(negedge clk);
                check_ready(ready, 1'b1, $sformatf("row %0d mt", idx));
            end
        end
        read_hilo(r.exp, $sformatf("row %0d", idx));  // issued as soon as ready is back
    endtask

    initial begin
        mdu_data_pkg::word_t a;
        mdu_data_pkg::word_t b;
        int unsigned         pick;
        seed       = 32'hcc33_2deb;
        n_mismatch = 0;
        n_other    = 0;
        model_hilo = '0;
        rst_n      = 1'b0;
        op         = '0;
        in0        = '0;
        in1        = '0;

        add_row(mdu_op_pkg::OP_MTHI,  32'h1234_5678, 32'h0000_0000);
        add_row(mdu_op_pkg::OP_MTLO,  32'hdead_beef, 32'h0000_0000);
        add_row(mdu_op_pkg::OP_MTHI,  32'h0bad_f00d, 32'h0000_0000);
        add_row(mdu_op_pkg::OP_MULT,  32'hffff_ffff, 32'hffff_ffff);
        add_row(mdu_op_pkg::OP_MULTU, 32'hffff_ffff, 32'hffff_ffff);
        add_row(mdu_op_pkg::OP_MULT,  32'h8000_0000, 32'h8000_0000);
        add_row(mdu_op_pkg::OP_MULT,  32'h8000_0000, 32'hffff_ffff);
        add_row(mdu_op_pkg::OP_MULTU, 32'h8000_0000, 32'h0000_0002);
        add_row(mdu_op_pkg::OP_MULT,  32'h0000_0000, 32'h1234_5678);
        add_row(mdu_op_pkg::OP_DIV,   32'hffff_fff9, 32'h0000_0002);  // -7 / 2
        add_row(mdu_op_pkg::OP_DIV,   32'h0000_0007, 32'hffff_fffe);  // 7 / -2
        add_row(mdu_op_pkg::OP_DIVU,  32'h0000_0064, 32'h0000_0007);
        add_row(mdu_op_pkg::OP_DIV,   32'h8000_0000, 32'hffff_ffff);
        add_row(mdu_op_pkg::OP_DIV,   32'h8000_0000, 32'h0000_0003);
        add_row(mdu_op_pkg::OP_DIV,   32'hffff_fffb, 32'h0000_0000);
        add_row(mdu_op_pkg::OP_DIVU,  32'h0000_dead, 32'h0000_0000);
        repeat (N_RAND) begin
            pick = $unsigned($random(seed)) % 6;
            a    = $random(seed);
            b    = $random(seed);
            if (($random(seed) & 7) == 0) b = '0;  // occasional divide by zero
            add_row(pick < 4 ? pick : pick + 2, a, b);
        end

        repeat (4) @(negedge clk);
        check_ready(ready, 1'b0, "in reset");
        rst_n = 1'b1;
        @(negedge clk);
        check_ready(ready, 1'b1, "after reset");
        read_hilo('0, "after reset");
        foreach (rows[i]) begin
            apply_row(rows[i], i);
        end

        $display("closing: %0d mismatches, %0d other errors", n_mismatch, n_other);
        if (n_mismatch + n_other == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("error at %0t: run did not finish within %0d ns", $time, WATCHDOG_NS);
        $display("closing: %0d mismatches, %0d other errors", n_mismatch, n_other + 1);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
